/* design/riscv_decode_pkg.sv */
`default_nettype none

package riscv_decode_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  opcode_t;
  typedef logic [4:0]  alu_op_t;
  typedef logic [1:0]  a_sel_t;
  typedef logic [2:0]  b_sel_t;
  typedef logic [2:0]  mem_size_t;
  typedef logic [10:0] insn_class_t;

  // Opcode field, instr[6:2]
  localparam opcode_t OP_OPCODE       = 5'b01100;
  localparam opcode_t OP_IMM_OPCODE   = 5'b00100;
  localparam opcode_t LUI_OPCODE      = 5'b01101;
  localparam opcode_t AUIPC_OPCODE    = 5'b00101;
  localparam opcode_t LOAD_OPCODE     = 5'b00000;
  localparam opcode_t STORE_OPCODE    = 5'b01000;
  localparam opcode_t BRANCH_OPCODE   = 5'b11000;
  localparam opcode_t JAL_OPCODE      = 5'b11011;
  localparam opcode_t JALR_OPCODE     = 5'b11001;
  localparam opcode_t MISC_MEM_OPCODE = 5'b00011;
  localparam opcode_t SYSTEM_OPCODE   = 5'b11100;

  // ALU operation codes with bit 4 set for comparisons
  localparam alu_op_t ALU_ADD  = 5'b00000;
  localparam alu_op_t ALU_SUB  = 5'b01000;
  localparam alu_op_t ALU_SLL  = 5'b00001;
  localparam alu_op_t ALU_SLTS = 5'b00010;
  localparam alu_op_t ALU_SLTU = 5'b00011;
  localparam alu_op_t ALU_XOR  = 5'b00100;
  localparam alu_op_t ALU_SRL  = 5'b00101;
  localparam alu_op_t ALU_SRA  = 5'b01101;
  localparam alu_op_t ALU_OR   = 5'b00110;
  localparam alu_op_t ALU_AND  = 5'b00111;
  localparam alu_op_t ALU_EQ   = 5'b11000;
  localparam alu_op_t ALU_NE   = 5'b11001;
  localparam alu_op_t ALU_LTS  = 5'b11100;
  localparam alu_op_t ALU_GES  = 5'b11101;
  localparam alu_op_t ALU_LTU  = 5'b11110;
  localparam alu_op_t ALU_GEU  = 5'b11111;

  // Operand selectors
  localparam a_sel_t OP_A_RS1  = 2'd0;
  localparam a_sel_t OP_A_PC   = 2'd1;
  localparam a_sel_t OP_A_ZERO = 2'd2;

  localparam b_sel_t OP_B_RS2   = 3'd0;
  localparam b_sel_t OP_B_IMM_I = 3'd1;
  localparam b_sel_t OP_B_IMM_U = 3'd2;
  localparam b_sel_t OP_B_IMM_S = 3'd3;
  localparam b_sel_t OP_B_INCR  = 3'd4;

  // Write-back source
  localparam logic WB_ALU = 1'b0;
  localparam logic WB_LSU = 1'b1;

  // Bit positions in the one-hot class vector
  localparam int unsigned CLS_OP     = 0;
  localparam int unsigned CLS_OP_IMM = 1;
  localparam int unsigned CLS_LUI    = 2;
  localparam int unsigned CLS_AUIPC  = 3;
  localparam int unsigned CLS_LOAD   = 4;
  localparam int unsigned CLS_STORE  = 5;
  localparam int unsigned CLS_BRANCH = 6;
  localparam int unsigned CLS_JAL    = 7;
  localparam int unsigned CLS_JALR   = 8;
  localparam int unsigned CLS_FENCE  = 9;
  localparam int unsigned CLS_SYSTEM = 10;

endpackage

`default_nettype wire

/* design/instr_legality_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_legality_checker (
  input  riscv_decode_pkg::instr_t      instr_i,
  output riscv_decode_pkg::insn_class_t cls_o,
  output logic                          illegal_o
);
  import riscv_decode_pkg::*;

  localparam logic [6:0]  FUNCT7_ZERO = 7'b0000000;
  localparam logic [6:0]  FUNCT7_ALT  = 7'b0100000;
  localparam logic [24:0] SYS_ECALL   = 25'd0;
  localparam logic [24:0] SYS_EBREAK  = 25'd8192;

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  insn_class_t cls_raw;
  logic        legal;

  assign opcode = instr_i[6:2];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    cls_raw = '0;
    legal   = 1'b0;
    // Compressed and reserved encodings never reach the case
    if (instr_i[1:0] == 2'b11) begin
      case (opcode)
        OP_OPCODE: begin
          cls_raw[CLS_OP] = 1'b1;
          legal = (funct7 == FUNCT7_ZERO) ||
                  ((funct7 == FUNCT7_ALT) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        end
        OP_IMM_OPCODE: begin
          cls_raw[CLS_OP_IMM] = 1'b1;
          case (funct3)
            3'b001:  legal = (funct7 == FUNCT7_ZERO);
            3'b101:  legal = (funct7 == FUNCT7_ZERO) || (funct7 == FUNCT7_ALT);
            default: legal = 1'b1;
          endcase
        end
        LUI_OPCODE: begin
          cls_raw[CLS_LUI] = 1'b1;
          legal = 1'b1;
        end
        AUIPC_OPCODE: begin
          cls_raw[CLS_AUIPC] = 1'b1;
          legal = 1'b1;
        end
        LOAD_OPCODE: begin
          cls_raw[CLS_LOAD] = 1'b1;
          legal = funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        end
        STORE_OPCODE: begin
          cls_raw[CLS_STORE] = 1'b1;
          legal = funct3 inside {3'd0, 3'd1, 3'd2};
        end
        BRANCH_OPCODE: begin
          cls_raw[CLS_BRANCH] = 1'b1;
          legal = !(funct3 inside {3'd2, 3'd3});
        end
        JAL_OPCODE: begin
          cls_raw[CLS_JAL] = 1'b1;
          legal = 1'b1;
        end
        JALR_OPCODE: begin
          cls_raw[CLS_JALR] = 1'b1;
          legal = (funct3 == 3'b000);
        end
        MISC_MEM_OPCODE: begin
          cls_raw[CLS_FENCE] = 1'b1;
          legal = (funct3 == 3'b000);
        end
        SYSTEM_OPCODE: begin
          cls_raw[CLS_SYSTEM] = 1'b1;
          legal = (instr_i[31:7] == SYS_ECALL) || (instr_i[31:7] == SYS_EBREAK);
        end
        default: legal = 1'b0;
      endcase
    end
  end

  // Illegal encodings carry no class
  assign cls_o     = legal ? cls_raw : '0;
  assign illegal_o = ~legal;

endmodule

`default_nettype wire

/* design/alu_op_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_op_decoder (
  input  riscv_decode_pkg::insn_class_t cls_i,
  input  logic [2:0]                    funct3_i,
  input  logic                          funct7_b5_i,
  output riscv_decode_pkg::alu_op_t     alu_op_o
);
  import riscv_decode_pkg::*;

  logic arith;
  logic sub_en;

  assign arith = cls_i[CLS_OP] | cls_i[CLS_OP_IMM];

  // No SUBI, so the alternate bit only counts for register ops
  assign sub_en = cls_i[CLS_OP] & funct7_b5_i;

  always_comb begin
    alu_op_o = ALU_ADD;
    if (arith) begin
      case (funct3_i)
        3'b000:  alu_op_o = sub_en ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op_o = ALU_SLL;
        3'b010:  alu_op_o = ALU_SLTS;
        3'b011:  alu_op_o = ALU_SLTU;
        3'b100:  alu_op_o = ALU_XOR;
        3'b101:  alu_op_o = funct7_b5_i ? ALU_SRA : ALU_SRL;
        3'b110:  alu_op_o = ALU_OR;
        default: alu_op_o = ALU_AND;
      endcase
    end else if (cls_i[CLS_BRANCH]) begin
      case (funct3_i)
        3'b000:  alu_op_o = ALU_EQ;
        3'b001:  alu_op_o = ALU_NE;
        3'b100:  alu_op_o = ALU_LTS;
        3'b101:  alu_op_o = ALU_GES;
        3'b110:  alu_op_o = ALU_LTU;
        3'b111:  alu_op_o = ALU_GEU;
        default: alu_op_o = ALU_ADD;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/ctrl_signal_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module ctrl_signal_gen (
  input  riscv_decode_pkg::insn_class_t cls_i,
  input  logic [2:0]                    funct3_i,
  output riscv_decode_pkg::a_sel_t      a_sel_o,
  output riscv_decode_pkg::b_sel_t      b_sel_o,
  output riscv_decode_pkg::mem_size_t   mem_size_o,
  output logic                          wb_sel_o,
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic                          gpr_we_o,
  output logic                          branch_o,
  output logic                          jal_o,
  output logic                          jalr_o
);
  import riscv_decode_pkg::*;

  logic mem_access;

  assign mem_access = cls_i[CLS_LOAD] | cls_i[CLS_STORE];

  //////////////////////////////////////////////////////////////////////////////
  // Operand selectors
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    a_sel_o = OP_A_RS1;
    b_sel_o = OP_B_RS2;
    case (1'b1)
      cls_i[CLS_OP_IMM],
      cls_i[CLS_LOAD]: b_sel_o = OP_B_IMM_I;
      cls_i[CLS_STORE]: b_sel_o = OP_B_IMM_S;
      cls_i[CLS_AUIPC]: begin
        a_sel_o = OP_A_PC;
        b_sel_o = OP_B_IMM_U;
      end
      cls_i[CLS_LUI]: begin
        a_sel_o = OP_A_ZERO;
        b_sel_o = OP_B_IMM_U;
      end
      // Link address is pc + 4
      cls_i[CLS_JAL],
      cls_i[CLS_JALR]: begin
        a_sel_o = OP_A_PC;
        b_sel_o = OP_B_INCR;
      end
      default: begin
        a_sel_o = OP_A_RS1;
        b_sel_o = OP_B_RS2;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////////
  // Enables and memory controls
  //////////////////////////////////////////////////////////////////////////////

  assign gpr_we_o = cls_i[CLS_OP] | cls_i[CLS_OP_IMM] | cls_i[CLS_LUI] |
                    cls_i[CLS_AUIPC] | cls_i[CLS_LOAD] | cls_i[CLS_JAL] |
                    cls_i[CLS_JALR];

  assign mem_req_o  = mem_access;
  assign mem_we_o   = cls_i[CLS_STORE];
  assign mem_size_o = mem_access ? funct3_i : '0;
  assign wb_sel_o   = cls_i[CLS_LOAD] ? WB_LSU : WB_ALU;

  assign branch_o = cls_i[CLS_BRANCH];
  assign jal_o    = cls_i[CLS_JAL];
  assign jalr_o   = cls_i[CLS_JALR];

endmodule

`default_nettype wire

/* design/id_output_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module id_output_reg (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        stall_i,
  input  logic                        illegal_i,
  input  riscv_decode_pkg::a_sel_t    a_sel_i,
  input  riscv_decode_pkg::b_sel_t    b_sel_i,
  input  riscv_decode_pkg::alu_op_t   alu_op_i,
  input  riscv_decode_pkg::mem_size_t mem_size_i,
  input  logic                        wb_sel_i,
  input  logic                        mem_req_i,
  input  logic                        mem_we_i,
  input  logic                        gpr_we_i,
  input  logic                        branch_i,
  input  logic                        jal_i,
  input  logic                        jalr_i,
  output riscv_decode_pkg::a_sel_t    a_sel_o,
  output riscv_decode_pkg::b_sel_t    b_sel_o,
  output riscv_decode_pkg::alu_op_t   alu_op_o,
  output riscv_decode_pkg::mem_size_t mem_size_o,
  output logic                        wb_sel_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic                        gpr_we_o,
  output logic                        illegal_instr_o,
  output logic                        branch_o,
  output logic                        jal_o,
  output logic                        jalr_o
);
  import riscv_decode_pkg::*;

  logic legal;

  assign legal = ~illegal_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_sel_o         <= OP_A_RS1;
      b_sel_o         <= OP_B_RS2;
      alu_op_o        <= ALU_ADD;
      mem_size_o      <= '0;
      wb_sel_o        <= WB_ALU;
      mem_req_o       <= 1'b0;
      mem_we_o        <= 1'b0;
      gpr_we_o        <= 1'b0;
      illegal_instr_o <= 1'b0;
      branch_o        <= 1'b0;
      jal_o           <= 1'b0;
      jalr_o          <= 1'b0;
    end else if (!stall_i) begin
      a_sel_o         <= a_sel_i;
      b_sel_o         <= b_sel_i;
      alu_op_o        <= alu_op_i;
      mem_size_o      <= mem_size_i;
      wb_sel_o        <= wb_sel_i;
      // Side effects masked for a trapping instruction
      mem_req_o       <= mem_req_i & legal;
      mem_we_o        <= mem_we_i & legal;
      gpr_we_o        <= gpr_we_i & legal;
      branch_o        <= branch_i & legal;
      jal_o           <= jal_i & legal;
      jalr_o          <= jalr_i & legal;
      illegal_instr_o <= illegal_i;
    end
  end

endmodule

`default_nettype wire

/* design/id_stage_top.sv */
`timescale 1ns/10ps
`default_nettype none

module id_stage_top (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  riscv_decode_pkg::instr_t    fetched_instr_i,
  input  logic                        stall_i,
  output riscv_decode_pkg::a_sel_t    a_sel_o,
  output riscv_decode_pkg::b_sel_t    b_sel_o,
  output riscv_decode_pkg::alu_op_t   alu_op_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output riscv_decode_pkg::mem_size_t mem_size_o,
  output logic                        gpr_we_o,
  output logic                        wb_sel_o,
  output logic                        illegal_instr_o,
  output logic                        branch_o,
  output logic                        jal_o,
  output logic                        jalr_o
);
  import riscv_decode_pkg::*;

  insn_class_t cls;
  logic        illegal;
  alu_op_t     alu_op;
  a_sel_t      a_sel;
  b_sel_t      b_sel;
  mem_size_t   mem_size;
  logic        wb_sel;
  logic        mem_req;
  logic        mem_we;
  logic        gpr_we;
  logic        branch;
  logic        jal;
  logic        jalr;

  //////////////////////////////////////////////////////////////////////////////
  // Combinational decode
  //////////////////////////////////////////////////////////////////////////////

  instr_legality_checker u_legality (
    .instr_i   (fetched_instr_i),
    .cls_o     (cls),
    .illegal_o (illegal)
  );

  alu_op_decoder u_alu_dec (
    .cls_i       (cls),
    .funct3_i    (fetched_instr_i[14:12]),
    .funct7_b5_i (fetched_instr_i[30]),
    .alu_op_o    (alu_op)
  );

  ctrl_signal_gen u_ctrl (
    .cls_i      (cls),
    .funct3_i   (fetched_instr_i[14:12]),
    .a_sel_o    (a_sel),
    .b_sel_o    (b_sel),
    .mem_size_o (mem_size),
    .wb_sel_o   (wb_sel),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .gpr_we_o   (gpr_we),
    .branch_o   (branch),
    .jal_o      (jal),
    .jalr_o     (jalr)
  );

  // One cycle of latency, held while stalled
  id_output_reg u_out_reg (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .stall_i         (stall_i),
    .illegal_i       (illegal),
    .a_sel_i         (a_sel),
    .b_sel_i         (b_sel),
    .alu_op_i        (alu_op),
    .mem_size_i      (mem_size),
    .wb_sel_i        (wb_sel),
    .mem_req_i       (mem_req),
    .mem_we_i        (mem_we),
    .gpr_we_i        (gpr_we),
    .branch_i        (branch),
    .jal_i           (jal),
    .jalr_i          (jalr),
    .a_sel_o         (a_sel_o),
    .b_sel_o         (b_sel_o),
    .alu_op_o        (alu_op_o),
    .mem_size_o      (mem_size_o),
    .wb_sel_o        (wb_sel_o),
    .mem_req_o       (mem_req_o),
    .mem_we_o        (mem_we_o),
    .gpr_we_o        (gpr_we_o),
    .illegal_instr_o (illegal_instr_o),
    .branch_o        (branch_o),
    .jal_o           (jal_o),
    .jalr_o          (jalr_o)
  );

endmodule

`default_nettype wire

/* tests/id_stage_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module id_stage_sva (
  input logic        clk_i,
  input logic        arst_n_i,
  input logic        stall_i,
  input logic        illegal_i,
  input logic [5:0]  enables_i,
  input logic [13:0] fields_i
);

  int unsigned fail_count = 0;

  // enables_i is {mem_req, mem_we, gpr_we, branch, jal, jalr}
  illegal_no_enable_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) illegal_i |-> (enables_i == 6'd0)
  ) else begin
    fail_count++;
    $error("Enable active together with illegal instruction flag");
  end

  one_jump_kind_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(enables_i[2:0])
  ) else begin
    fail_count++;
    $error("More than one of branch, jal and jalr set");
  end

  stall_hold_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      stall_i |=> $stable({fields_i, enables_i, illegal_i})
  ) else begin
    fail_count++;
    $error("Decode outputs changed across a stalled cycle");
  end

endmodule

bind id_stage_top id_stage_sva u_sva (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .stall_i   (stall_i),
  .illegal_i (illegal_instr_o),
  .enables_i ({mem_req_o, mem_we_o, gpr_we_o, branch_o, jal_o, jalr_o}),
  .fields_i  ({a_sel_o, b_sel_o, alu_op_o, mem_size_o, wb_sel_o})
);

`default_nettype wire

/* tests/tb_id_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage;
  import riscv_decode_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 3000;
  localparam int unsigned RANDOM_COUNT   = 2000;

  typedef struct packed {
    a_sel_t    a_sel;
    b_sel_t    b_sel;
    alu_op_t   alu_op;
    mem_size_t mem_size;
    logic      wb_sel;
    logic      mem_req;
    logic      mem_we;
    logic      gpr_we;
    logic      illegal;
    logic      branch;
    logic      jal;
    logic      jalr;
  } ctrl_word_t;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        stall;
  instr_t      instr;
  a_sel_t      a_sel;
  b_sel_t      b_sel;
  alu_op_t     alu_op;
  logic        mem_req;
  logic        mem_we;
  mem_size_t   mem_size;
  logic        gpr_we;
  logic        wb_sel;
  logic        illegal_instr;
  logic        branch;
  logic        jal;
  logic        jalr;
  ctrl_word_t  exp_word = '0;
  int unsigned errors = 0;
  int unsigned cycle_cnt = 0;

  opcode_t legal_opcodes [11] = '{OP_OPCODE, OP_IMM_OPCODE, LUI_OPCODE, AUIPC_OPCODE,
                                  LOAD_OPCODE, STORE_OPCODE, BRANCH_OPCODE, JAL_OPCODE,
                                  JALR_OPCODE, MISC_MEM_OPCODE, SYSTEM_OPCODE};

  // Branch comparison by funct3 with 2 and 3 unused
  alu_op_t br_ops [8] = '{ALU_EQ, ALU_NE, ALU_ADD, ALU_ADD, ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU};

  always #2 clk = ~clk;

  id_stage_top u_id_stage_top (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .fetched_instr_i (instr),
    .stall_i         (stall),
    .a_sel_o         (a_sel),
    .b_sel_o         (b_sel),
    .alu_op_o        (alu_op),
    .mem_req_o       (mem_req),
    .mem_we_o        (mem_we),
    .mem_size_o      (mem_size),
    .gpr_we_o        (gpr_we),
    .wb_sel_o        (wb_sel),
    .illegal_instr_o (illegal_instr),
    .branch_o        (branch),
    .jal_o           (jal),
    .jalr_o          (jalr)
  );

  //////////////////////////////////////////////////////////////////////////////
  // Reference decode
  //////////////////////////////////////////////////////////////////////////////

  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLTS;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic ctrl_word_t decode_ref(input instr_t ins);
    ctrl_word_t w;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    w  = '0;
    f3 = ins[14:12];
    f7 = ins[31:25];
    ok = 1'b0;
    if (ins[1:0] == 2'b11) begin
      case (ins[6:2])
        OP_OPCODE: begin
          ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
          w.alu_op = arith_op(f3, f7[5]);
          w.gpr_we = 1'b1;
        end
        OP_IMM_OPCODE: begin
          ok = (f3 == 3'd1) ? (f7 == 7'h00) :
               (f3 == 3'd5) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;
          // Only shifts look at bit 30
          w.alu_op = arith_op(f3, f7[5] && (f3 == 3'd5));
          w.b_sel  = OP_B_IMM_I;
          w.gpr_we = 1'b1;
        end
        LUI_OPCODE: begin
          ok = 1'b1;
          w.a_sel  = OP_A_ZERO;
          w.b_sel  = OP_B_IMM_U;
          w.gpr_we = 1'b1;
        end
        AUIPC_OPCODE: begin
          ok = 1'b1;
          w.a_sel  = OP_A_PC;
          w.b_sel  = OP_B_IMM_U;
          w.gpr_we = 1'b1;
        end
        LOAD_OPCODE: begin
          ok = (f3 != 3'd3) && (f3 < 3'd6);
          w.b_sel    = OP_B_IMM_I;
          w.mem_req  = 1'b1;
          w.mem_size = f3;
          w.wb_sel   = WB_LSU;
          w.gpr_we   = 1'b1;
        end
        STORE_OPCODE: begin
          ok = (f3 < 3'd3);
          w.b_sel    = OP_B_IMM_S;
          w.mem_req  = 1'b1;
          w.mem_we   = 1'b1;
          w.mem_size = f3;
        end
        BRANCH_OPCODE: begin
          ok = (f3[2:1] != 2'b01);
          w.alu_op = br_ops[f3];
          w.branch = 1'b1;
        end
        JAL_OPCODE, JALR_OPCODE: begin
          ok = (ins[6:2] == JAL_OPCODE) || (f3 == 3'd0);
          w.a_sel  = OP_A_PC;
          w.b_sel  = OP_B_INCR;
          w.gpr_we = 1'b1;
          w.jal    = (ins[6:2] == JAL_OPCODE);
          w.jalr   = (ins[6:2] == JALR_OPCODE);
        end
        MISC_MEM_OPCODE: ok = (f3 == 3'd0);
        // ecall or ebreak only
        SYSTEM_OPCODE:   ok = (ins[31:7] == 25'd0) || (ins[31:7] == 25'd8192);
        default:         ok = 1'b0;
      endcase
    end
    if (!ok) begin
      w = '0;
      w.illegal = 1'b1;
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////////////

  function automatic instr_t encode_instr(input opcode_t op, input logic [2:0] f3,
                                          input logic [6:0] f7);
    instr_t ins;
    ins        = $urandom;
    ins[6:0]   = {op, 2'b11};
    ins[14:12] = f3;
    ins[31:25] = f7;
    return ins;
  endfunction

  // Stalled cycles carry junk that must not be captured
  task automatic send_instr(input instr_t ins);
    while (($urandom % 5) == 0) begin
      @(posedge clk);
      stall <= 1'b1;
      instr <= $urandom;
    end
    @(posedge clk);
    stall <= 1'b0;
    instr <= ins;
  endtask

  task automatic check_field(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Expected word and compare
  //////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (arst_n && !stall) begin
      exp_word <= decode_ref(instr);
    end
  end

  always @(negedge clk) begin
    check_field("a_sel", a_sel, exp_word.a_sel);
    check_field("b_sel", b_sel, exp_word.b_sel);
    check_field("alu_op", alu_op, exp_word.alu_op);
    check_field("mem_size", mem_size, exp_word.mem_size);
    check_field("wb_sel", wb_sel, exp_word.wb_sel);
    check_field("mem_req", mem_req, exp_word.mem_req);
    check_field("mem_we", mem_we, exp_word.mem_we);
    check_field("gpr_we", gpr_we, exp_word.gpr_we);
    check_field("illegal_instr", illegal_instr, exp_word.illegal);
    check_field("branch", branch, exp_word.branch);
    check_field("jal", jal, exp_word.jal);
    check_field("jalr", jalr, exp_word.jalr);
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////////////

  initial begin
    instr_t      ins;
    int unsigned sva_fails;
    void'($urandom(32'h6e79));
    arst_n = 1'b0;
    stall  = 1'b1;
    instr  = '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    // Outputs stay at reset values until the first capture
    repeat (2) @(posedge clk);

    for (int f = 0; f < 8; f++) begin
      send_instr(encode_instr(OP_OPCODE, f[2:0], 7'h00));
      send_instr(encode_instr(OP_OPCODE, f[2:0], 7'h20));
      send_instr(encode_instr(OP_IMM_OPCODE, f[2:0], 7'h00));
      send_instr(encode_instr(OP_IMM_OPCODE, f[2:0], 7'h20));
      send_instr(encode_instr(LOAD_OPCODE, f[2:0], 7'($urandom)));
      send_instr(encode_instr(STORE_OPCODE, f[2:0], 7'($urandom)));
      send_instr(encode_instr(BRANCH_OPCODE, f[2:0], 7'($urandom)));
    end
    send_instr(encode_instr(OP_OPCODE, 3'd0, 7'h01));
    send_instr(encode_instr(OP_IMM_OPCODE, 3'd5, 7'h01));
    send_instr(encode_instr(LUI_OPCODE, 3'($urandom), 7'($urandom)));
    send_instr(encode_instr(AUIPC_OPCODE, 3'($urandom), 7'($urandom)));
    send_instr(encode_instr(JAL_OPCODE, 3'($urandom), 7'($urandom)));
    send_instr(encode_instr(JALR_OPCODE, 3'd0, 7'($urandom)));
    send_instr(encode_instr(JALR_OPCODE, 3'd1, 7'($urandom)));
    send_instr(encode_instr(MISC_MEM_OPCODE, 3'd0, 7'($urandom)));
    send_instr(encode_instr(MISC_MEM_OPCODE, 3'd1, 7'($urandom)));
    send_instr(32'h00000073);
    send_instr(32'h00100073);
    send_instr(32'h00001073);
    send_instr(32'h000000f3);
    send_instr(encode_instr(5'b11111, 3'd0, 7'h00));
    send_instr(encode_instr(5'b01110, 3'd0, 7'h00));
    send_instr(32'h00000030);
    send_instr(32'h00000031);
    send_instr(32'h00000032);

    repeat (RANDOM_COUNT / 2) begin
      ins      = $urandom;
      ins[6:0] = {legal_opcodes[$urandom % 11], 2'b11};
      send_instr(ins);
      send_instr($urandom);
    end

    @(posedge clk);
    stall <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    sva_fails = u_id_stage_top.u_sva.fail_count;
    $display("Run complete: %0d field errors, %0d assertion failures", errors, sva_fails);
    if ((errors == 0) && (sva_fails == 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
design/riscv_decode_pkg.sv
design/instr_legality_checker.sv
design/alu_op_decoder.sv
design/ctrl_signal_gen.sv
design/id_output_reg.sv
design/id_stage_top.sv
tests/id_stage_sva.sv
tests/tb_id_stage.sv
